//--- src/lsq_pkg.sv
package lsq_pkg;

    // queue geometry, one slot always stays empty so 7 are usable
    localparam int lsq_size = 8;
    localparam int lsq_idx_w = 3;

    // datapath widths
    localparam int xlen = 32;
    localparam int line_w = 64;
    localparam int rob_tag_w = 5;
    // cache transaction tag, zero means no transaction
    localparam int cache_tag_w = 4;

    typedef enum logic [1:0] {
        mem_byte   = 2'd0,
        mem_half   = 2'd1,
        mem_word   = 2'd2,
        mem_double = 2'd3
    } mem_size_e;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_cmd_e;

    // packet from dispatch, one memory op per cycle
    typedef struct packed {
        logic                 valid;
        logic                 rd_mem;
        logic                 wr_mem;
        logic                 rd_unsigned;
        logic [rob_tag_w-1:0] rob_tag;
        mem_size_e            mem_size;
        logic [xlen-1:0]      store_data;
        logic                 store_data_valid;
        // producer tag to watch on the CDB when data is pending
        logic [rob_tag_w-1:0] store_data_tag;
    } lsq_dispatch_t;

    // address from execute, matched against the slot rob tag
    typedef struct packed {
        logic                 valid;
        logic [rob_tag_w-1:0] rob_tag;
        logic [xlen-1:0]      addr;
    } addr_bcast_t;

    // CDB message, used for both the input and the load broadcast
    typedef struct packed {
        logic                 valid;
        logic [rob_tag_w-1:0] tag;
        logic [xlen-1:0]      value;
    } cdb_t;

    // state of one queue slot
    typedef struct packed {
        logic                 valid;
        logic                 is_store;
        logic                 retired;
        logic                 rd_unsigned;
        logic [rob_tag_w-1:0] rob_tag;
        logic [xlen-1:0]      address;
        logic                 address_valid;
        logic [xlen-1:0]      store_data;
        logic                 store_data_valid;
        logic [rob_tag_w-1:0] store_data_tag;
        mem_size_e            mem_size;
    } lsq_entry_t;

    // request to the data cache
    typedef struct packed {
        bus_cmd_e           command;
        logic [xlen-1:0]    addr;
        logic [line_w-1:0]  data;
        mem_size_e          size;
    } cache_req_t;

endpackage

//--- src/lsq_entry.sv
`timescale 1ns/1ns

module lsq_entry (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              alloc,
    input  logic                              free,
    input  lsq_pkg::lsq_dispatch_t            dispatch,
    input  lsq_pkg::addr_bcast_t              addr_in,
    input  lsq_pkg::cdb_t                     cdb_in,
    input  logic                              mem_valid,
    input  logic [lsq_pkg::rob_tag_w-1:0]     mem_tag,
    output lsq_pkg::lsq_entry_t               entry
);

    // control flags
    logic valid;
    logic retired;
    logic address_valid;
    logic store_data_valid;

    // payload captured at dispatch or filled in later
    logic                          is_store;
    logic                          rd_unsigned;
    logic [lsq_pkg::rob_tag_w-1:0] rob_tag;
    logic [lsq_pkg::xlen-1:0]      address;
    logic [lsq_pkg::xlen-1:0]      store_data;
    logic [lsq_pkg::rob_tag_w-1:0] store_data_tag;
    lsq_pkg::mem_size_e            mem_size;

    logic addr_hit;
    logic data_hit;
    logic retire_hit;

    // execute sends the address once, keyed by the rob tag
    assign addr_hit = valid && !address_valid && addr_in.valid && (addr_in.rob_tag == rob_tag);
    // pending store data snooped off the CDB
    assign data_hit = valid && is_store && !store_data_valid && cdb_in.valid
                      && (cdb_in.tag == store_data_tag);
    // retire stage gives the store permission to write
    assign retire_hit = valid && is_store && mem_valid && (mem_tag == rob_tag);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid            <= 1'b0;
            retired          <= 1'b0;
            address_valid    <= 1'b0;
            store_data_valid <= 1'b0;
        end else if (alloc) begin
            valid            <= 1'b1;
            retired          <= 1'b0;
            address_valid    <= 1'b0;
            // data may already be known at dispatch
            store_data_valid <= dispatch.store_data_valid;
        end else if (free) begin
            valid <= 1'b0;
        end else begin
            if (addr_hit)
                address_valid <= 1'b1;
            if (data_hit)
                store_data_valid <= 1'b1;
            if (retire_hit)
                retired <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            is_store       <= dispatch.wr_mem;
            rd_unsigned    <= dispatch.rd_unsigned;
            rob_tag        <= dispatch.rob_tag;
            mem_size       <= dispatch.mem_size;
            store_data     <= dispatch.store_data;
            store_data_tag <= dispatch.store_data_tag;
        end else begin
            if (addr_hit)
                address <= addr_in.addr;
            // only the low word of a store is carried
            if (data_hit)
                store_data <= cdb_in.value;
        end
    end

    always_comb begin
        entry.valid            = valid;
        entry.is_store         = is_store;
        entry.retired          = retired;
        entry.rd_unsigned      = rd_unsigned;
        entry.rob_tag          = rob_tag;
        entry.address          = address;
        entry.address_valid    = address_valid;
        entry.store_data       = store_data;
        entry.store_data_valid = store_data_valid;
        entry.store_data_tag   = store_data_tag;
        entry.mem_size         = mem_size;
    end

endmodule

//--- src/lsq_alloc.sv
`timescale 1ns/1ns

module lsq_alloc (
    input  logic                           clk,
    input  logic                           reset,
    input  lsq_pkg::lsq_dispatch_t         dispatch,
    input  logic [lsq_pkg::lsq_idx_w-1:0]  head_ptr,
    output logic [lsq_pkg::lsq_size-1:0]   alloc,
    output logic                           lsq_free
);

    // next slot to fill
    logic [lsq_pkg::lsq_idx_w-1:0] tail_ptr;
    logic [lsq_pkg::lsq_idx_w-1:0] next_tail;
    logic                          is_mem_op;
    logic                          full;
    logic                          accept;

    // pointer wraps naturally, the queue size is a power of two
    assign next_tail = tail_ptr + 1'b1;

    // full when one more entry would make tail catch head
    assign full = (next_tail == head_ptr);
    assign lsq_free = !full;

    assign is_mem_op = dispatch.valid && (dispatch.rd_mem || dispatch.wr_mem);
    // sender holds the packet while the queue is full
    assign accept = is_mem_op && !full;

    // one-hot write strobe to the tail slot
    always_comb begin
        alloc = '0;
        if (accept)
            alloc[tail_ptr] = 1'b1;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tail_ptr <= '0;
        end else if (accept) begin
            tail_ptr <= next_tail;
        end
    end

endmodule

//--- src/load_extend.sv
`timescale 1ns/1ns

module load_extend (
    input  logic [lsq_pkg::line_w-1:0] line,
    input  logic                       upper_half,
    input  lsq_pkg::mem_size_e         size,
    input  logic                       is_unsigned,
    output logic [lsq_pkg::xlen-1:0]   value
);

    // the 32-bit word picked out of the line
    logic [lsq_pkg::xlen-1:0] word;

    // address bit 2 chooses the half of the 64-bit line
    assign word = upper_half ? line[lsq_pkg::line_w-1:lsq_pkg::xlen]
                             : line[lsq_pkg::xlen-1:0];

    always_comb begin
        value = word;
        case (size)
            lsq_pkg::mem_byte: begin
                if (is_unsigned)
                    value = {{(lsq_pkg::xlen-8){1'b0}}, word[7:0]};
                else
                    value = {{(lsq_pkg::xlen-8){word[7]}}, word[7:0]};
            end
            lsq_pkg::mem_half: begin
                if (is_unsigned)
                    value = {{(lsq_pkg::xlen-16){1'b0}}, word[15:0]};
                else
                    value = {{(lsq_pkg::xlen-16){word[15]}}, word[15:0]};
            end
            // word and double return the selected word as is
            default: value = word;
        endcase
    end

endmodule

//--- src/lsq_issue.sv
`timescale 1ns/1ns

module lsq_issue (
    input  logic                             clk,
    input  logic                             reset,
    input  lsq_pkg::lsq_entry_t              entries [lsq_pkg::lsq_size],
    input  logic [lsq_pkg::line_w-1:0]       dcache_data_out,
    input  logic [lsq_pkg::cache_tag_w-1:0]  dcache_response,
    input  logic [lsq_pkg::cache_tag_w-1:0]  dcache_tag,
    input  logic                             dcache_hit,
    output logic [lsq_pkg::lsq_idx_w-1:0]    head_ptr,
    output logic [lsq_pkg::lsq_size-1:0]     free,
    output lsq_pkg::cache_req_t              cache_req,
    output lsq_pkg::cdb_t                    cdb_out,
    output logic                             store_ready,
    output logic [lsq_pkg::rob_tag_w-1:0]    store_ready_tag
);

    // what is needed to finish the one outstanding miss
    typedef struct packed {
        logic [lsq_pkg::cache_tag_w-1:0] cache_tag;
        logic [lsq_pkg::rob_tag_w-1:0]   rob_tag;
        logic                            upper_half;
        lsq_pkg::mem_size_e              mem_size;
        logic                            rd_unsigned;
    } miss_rec_t;

    lsq_pkg::lsq_entry_t head;
    logic                head_ready;
    logic                miss_valid;
    miss_rec_t           miss;

    logic req_accepted;
    logic load_hit;
    logic load_miss;
    logic store_done;
    logic miss_return;
    logic retire_head;

    // extender operands, from the head on a hit or the record on a return
    logic                     ext_upper;
    lsq_pkg::mem_size_e       ext_size;
    logic                     ext_unsigned;
    logic [lsq_pkg::xlen-1:0] ext_value;

    // registered load broadcast
    logic                          bcast_valid;
    logic [lsq_pkg::rob_tag_w-1:0] bcast_tag;
    logic [lsq_pkg::xlen-1:0]      bcast_value;

    assign head = entries[head_ptr];

    // loads need only an address, stores also need data and retirement
    assign head_ready = head.valid && head.address_valid
                        && (!head.is_store || (head.store_data_valid && head.retired));

    // rob may retire the store once it is fully formed at the head
    assign store_ready = head.valid && head.is_store && head.address_valid
                         && head.store_data_valid && !miss_valid;
    assign store_ready_tag = head.rob_tag;

    // request is held steady until the cache takes it
    always_comb begin
        cache_req.command = lsq_pkg::bus_none;
        cache_req.addr    = '0;
        cache_req.data    = '0;
        cache_req.size    = lsq_pkg::mem_byte;
        if (head_ready) begin
            if (head.is_store) begin
                cache_req.command = lsq_pkg::bus_store;
                cache_req.addr    = head.address;
                cache_req.data    = {{(lsq_pkg::line_w-lsq_pkg::xlen){1'b0}}, head.store_data};
                cache_req.size    = head.mem_size;
            end else if (!miss_valid) begin
                // blocking, no second load while one is outstanding
                cache_req.command = lsq_pkg::bus_load;
                cache_req.addr    = head.address;
                cache_req.size    = head.mem_size;
            end
        end
    end

    assign req_accepted = (cache_req.command != lsq_pkg::bus_none) && (dcache_response != '0);
    assign load_hit     = req_accepted && (cache_req.command == lsq_pkg::bus_load) && dcache_hit;
    assign load_miss    = req_accepted && (cache_req.command == lsq_pkg::bus_load) && !dcache_hit;
    assign store_done   = req_accepted && (cache_req.command == lsq_pkg::bus_store);
    assign miss_return  = miss_valid && (dcache_tag != '0) && (dcache_tag == miss.cache_tag);
    assign retire_head  = load_hit || miss_return || store_done;

    always_comb begin
        free = '0;
        if (retire_head)
            free[head_ptr] = 1'b1;
    end

    assign ext_upper    = miss_return ? miss.upper_half  : head.address[2];
    assign ext_size     = miss_return ? miss.mem_size    : head.mem_size;
    assign ext_unsigned = miss_return ? miss.rd_unsigned : head.rd_unsigned;

    load_extend u_load_extend (
        .line        (dcache_data_out),
        .upper_half  (ext_upper),
        .size        (ext_size),
        .is_unsigned (ext_unsigned),
        .value       (ext_value)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head_ptr    <= '0;
            miss_valid  <= 1'b0;
            bcast_valid <= 1'b0;
        end else begin
            // broadcast lasts exactly one cycle
            bcast_valid <= load_hit || miss_return;
            if (retire_head)
                head_ptr <= head_ptr + 1'b1;
            if (load_miss)
                miss_valid <= 1'b1;
            else if (miss_return)
                miss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_miss) begin
            miss.cache_tag   <= dcache_response;
            miss.rob_tag     <= head.rob_tag;
            miss.upper_half  <= head.address[2];
            miss.mem_size    <= head.mem_size;
            miss.rd_unsigned <= head.rd_unsigned;
        end
        if (load_hit || miss_return) begin
            bcast_tag   <= miss_return ? miss.rob_tag : head.rob_tag;
            bcast_value <= ext_value;
        end
    end

    always_comb begin
        cdb_out.valid = bcast_valid;
        cdb_out.tag   = bcast_tag;
        cdb_out.value = bcast_value;
    end

endmodule

//--- src/lsq.sv
`timescale 1ns/1ns

module lsq (
    input  logic                             clk,
    input  logic                             reset,

    // dispatch, execute, CDB and retire
    input  lsq_pkg::lsq_dispatch_t           dispatch,
    input  lsq_pkg::addr_bcast_t             addr_in,
    input  lsq_pkg::cdb_t                    cdb_in,
    input  logic                             mem_valid,
    input  logic [lsq_pkg::rob_tag_w-1:0]    mem_tag,

    // data cache side
    input  logic [lsq_pkg::line_w-1:0]       dcache_data_out,
    input  logic [lsq_pkg::cache_tag_w-1:0]  dcache_response,
    input  logic                             dcache_hit,
    input  logic [lsq_pkg::cache_tag_w-1:0]  dcache_tag,
    output lsq_pkg::cache_req_t              cache_req,

    // load results and status
    output lsq_pkg::cdb_t                    cdb_out,
    output logic                             store_ready,
    output logic [lsq_pkg::rob_tag_w-1:0]    store_ready_tag,
    output logic                             lsq_free
);

    logic [lsq_pkg::lsq_idx_w-1:0] head_ptr;
    // one-hot per slot strobes
    logic [lsq_pkg::lsq_size-1:0]  alloc;
    logic [lsq_pkg::lsq_size-1:0]  free;
    lsq_pkg::lsq_entry_t           entries [lsq_pkg::lsq_size];

    lsq_alloc u_alloc (
        .clk      (clk),
        .reset    (reset),
        .dispatch (dispatch),
        .head_ptr (head_ptr),
        .alloc    (alloc),
        .lsq_free (lsq_free)
    );

    // all slots see the broadcasts, each matches its own tags
    for (genvar i = 0; i < lsq_pkg::lsq_size; i++) begin : g_slot
        lsq_entry u_entry (
            .clk       (clk),
            .reset     (reset),
            .alloc     (alloc[i]),
            .free      (free[i]),
            .dispatch  (dispatch),
            .addr_in   (addr_in),
            .cdb_in    (cdb_in),
            .mem_valid (mem_valid),
            .mem_tag   (mem_tag),
            .entry     (entries[i])
        );
    end

    lsq_issue u_issue (
        .clk             (clk),
        .reset           (reset),
        .entries         (entries),
        .dcache_data_out (dcache_data_out),
        .dcache_response (dcache_response),
        .dcache_tag      (dcache_tag),
        .dcache_hit      (dcache_hit),
        .head_ptr        (head_ptr),
        .free            (free),
        .cache_req       (cache_req),
        .cdb_out         (cdb_out),
        .store_ready     (store_ready),
        .store_ready_tag (store_ready_tag)
    );

endmodule

//--- verif/lsq_tb.sv
`timescale 1ns/1ns

module lsq_tb;

    logic                   clk;
    logic                   reset;
    lsq_pkg::lsq_dispatch_t dispatch;
    lsq_pkg::addr_bcast_t   addr_in;
    lsq_pkg::cdb_t          cdb_in;
    logic                   mem_valid;
    logic [4:0]             mem_tag;
    logic [63:0]            dcache_data_out;
    logic [3:0]             dcache_response;
    logic                   dcache_hit;
    logic [3:0]             dcache_tag;
    lsq_pkg::cache_req_t    cache_req;
    lsq_pkg::cdb_t          cdb_out;
    logic                   store_ready;
    logic [4:0]             store_ready_tag;
    logic                   lsq_free;

    logic [31:0] lfsr = 32'h1db3_5bb9;
    int          cycles = 0;

    lsq dut0 (
        .clk(clk), .reset(reset), .dispatch(dispatch), .addr_in(addr_in), .cdb_in(cdb_in),
        .mem_valid(mem_valid), .mem_tag(mem_tag), .dcache_data_out(dcache_data_out),
        .dcache_response(dcache_response), .dcache_hit(dcache_hit), .dcache_tag(dcache_tag),
        .cache_req(cache_req), .cdb_out(cdb_out), .store_ready(store_ready),
        .store_ready_tag(store_ready_tag), .lsq_free(lsq_free)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // about 100 cycles of tests, so 600 leaves plenty of margin
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 600) begin
            $display("timeout: the run did not finish within 600 clock cycles");
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[62:0], fb};
        end
        return r;
    endfunction

    // expected load result: pick the line half by addr bit 2, then extend
    function automatic logic [31:0] expect_load(input logic [63:0] line, input logic hi,
                                                input lsq_pkg::mem_size_e size, input logic uns);
        logic [31:0] w;
        w = hi ? line[63:32] : line[31:0];
        if (size == lsq_pkg::mem_byte)
            return uns ? {24'h0, w[7:0]} : {{24{w[7]}}, w[7:0]};
        if (size == lsq_pkg::mem_half)
            return uns ? {16'h0, w[15:0]} : {{16{w[15]}}, w[15:0]};
        return w;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    // inputs change only here, on the falling edge
    task automatic next_cycle();
        @(negedge clk);
    endtask

    task automatic dispatch_op(input logic wr, input logic [4:0] tag,
                               input lsq_pkg::mem_size_e size, input logic uns);
        dispatch = '0;
        dispatch.valid = 1'b1;
        dispatch.rd_mem = !wr;
        dispatch.wr_mem = wr;
        dispatch.rd_unsigned = uns;
        dispatch.rob_tag = tag;
        dispatch.mem_size = size;
        // stores wait for their data on the CDB under tag 7
        dispatch.store_data_tag = 5'd7;
        next_cycle();
        dispatch.valid = 1'b0;
    endtask

    task automatic send_addr(input logic [4:0] tag, input logic [31:0] addr);
        addr_in = {1'b1, tag, addr};
        next_cycle();
        addr_in.valid = 1'b0;
    endtask

    task automatic wait_cmd(input lsq_pkg::bus_cmd_e cmd);
        while (cache_req.command != cmd)
            next_cycle();
    endtask

    // plays a cache hit for the head load and checks the broadcast after it
    task automatic hit_and_check(input logic [4:0] tag, input logic [31:0] addr,
                                 input lsq_pkg::mem_size_e size, input logic uns);
        logic [63:0] line;
        line = rand_bits(64);
        wait_cmd(lsq_pkg::bus_load);
        check(cache_req.addr, addr, "load address");
        check(cache_req.size, size, "load size");
        dcache_response = 4'd1;
        dcache_hit = 1'b1;
        dcache_data_out = line;
        next_cycle();
        dcache_response = '0;
        dcache_hit = 1'b0;
        check(cdb_out.valid, 1'b1, "hit broadcast valid");
        check(cdb_out.tag, tag, "hit broadcast tag");
        check(cdb_out.value, expect_load(line, addr[2], size, uns), "hit broadcast value");
    endtask

    task automatic test_reset_state();
        check(lsq_free, 1'b1, "lsq_free after reset");
        check(store_ready, 1'b0, "store_ready after reset");
        check(cdb_out.valid, 1'b0, "cdb_out valid after reset");
        check(cache_req.command, lsq_pkg::bus_none, "command after reset");
    endtask

    // every size, sign and line half
    task automatic test_load_hits();
        logic [31:0] addr;
        logic [4:0]  tag;
        tag = 5'd0;
        for (int s = 0; s < 3; s++) begin
            for (int u = 0; u < 2; u++) begin
                for (int h = 0; h < 2; h++) begin
                    addr = rand_bits(32);
                    addr[2] = h[0];
                    dispatch_op(1'b0, tag, lsq_pkg::mem_size_e'(s), u[0]);
                    send_addr(tag, addr);
                    hit_and_check(tag, addr, lsq_pkg::mem_size_e'(s), u[0]);
                    next_cycle();
                    check(cdb_out.valid, 1'b0, "broadcast lasts one cycle");
                    tag = tag + 5'd1;
                end
            end
        end
    endtask

    task automatic test_blocking_miss();
        logic [31:0] addr_a;
        logic [31:0] addr_b;
        logic [63:0] line;
        addr_a = rand_bits(32) | 32'h4;
        addr_b = rand_bits(32);
        line = rand_bits(64);
        dispatch_op(1'b0, 5'd20, lsq_pkg::mem_half, 1'b0);
        dispatch_op(1'b0, 5'd21, lsq_pkg::mem_byte, 1'b1);
        send_addr(5'd20, addr_a);
        send_addr(5'd21, addr_b);
        wait_cmd(lsq_pkg::bus_load);
        check(cache_req.addr, addr_a, "first load address");
        // accepted without a hit, cache tag 5 tracks the miss
        dcache_response = 4'd5;
        next_cycle();
        dcache_response = '0;
        repeat (3) begin
            check(cache_req.command, lsq_pkg::bus_none, "command during miss");
            check(cdb_out.valid, 1'b0, "no broadcast during miss");
            next_cycle();
        end
        dcache_tag = 4'd5;
        dcache_data_out = line;
        next_cycle();
        dcache_tag = '0;
        check(cdb_out.valid, 1'b1, "miss broadcast valid");
        check(cdb_out.tag, 5'd20, "miss broadcast tag");
        check(cdb_out.value, expect_load(line, 1'b1, lsq_pkg::mem_half, 1'b0),
              "miss broadcast value");
        hit_and_check(5'd21, addr_b, lsq_pkg::mem_byte, 1'b1);
        next_cycle();
    endtask

    task automatic test_store();
        logic [31:0] addr;
        logic [31:0] data;
        addr = rand_bits(32);
        data = rand_bits(32);
        dispatch_op(1'b1, 5'd25, lsq_pkg::mem_word, 1'b0);
        cdb_in = {1'b1, 5'd7, data};
        next_cycle();
        cdb_in.valid = 1'b0;
        send_addr(5'd25, addr);
        check(store_ready, 1'b1, "store_ready with address and data");
        check(store_ready_tag, 5'd25, "store_ready_tag");
        check(cache_req.command, lsq_pkg::bus_none, "store held until retired");
        mem_valid = 1'b1;
        mem_tag = 5'd25;
        next_cycle();
        mem_valid = 1'b0;
        check(cache_req.command, lsq_pkg::bus_store, "store command");
        check(cache_req.addr, addr, "store address");
        check(cache_req.data, {32'h0, data}, "store data");
        dcache_response = 4'd3;
        next_cycle();
        dcache_response = '0;
        check(store_ready, 1'b0, "store_ready after store accepted");
        check(cdb_out.valid, 1'b0, "no broadcast for store");
        next_cycle();
        check(cdb_out.valid, 1'b0, "no broadcast for store later");
    endtask

    task automatic test_full_order();
        for (int i = 0; i < 7; i++)
            dispatch_op(1'b0, 5'(i), lsq_pkg::mem_word, 1'b0);
        check(lsq_free, 1'b0, "lsq_free with seven entries");
        // eighth load must be ignored while full
        dispatch_op(1'b0, 5'd7, lsq_pkg::mem_word, 1'b0);
        check(lsq_free, 1'b0, "lsq_free after ignored dispatch");
        for (int i = 6; i >= 0; i--)
            send_addr(5'(i), 32'h1000 + 32'(i) * 32'd4);
        for (int i = 0; i < 7; i++)
            hit_and_check(5'(i), 32'h1000 + 32'(i) * 32'd4, lsq_pkg::mem_word, 1'b0);
        next_cycle();
        check(lsq_free, 1'b1, "lsq_free after drain");
        // an address for the ignored load finds no slot
        send_addr(5'd7, 32'h2000);
        check(cache_req.command, lsq_pkg::bus_none, "ignored dispatch left no entry");
    endtask

    initial begin
        reset = 1'b1;
        dispatch = '0;
        addr_in = '0;
        cdb_in = '0;
        mem_valid = 1'b0;
        mem_tag = '0;
        dcache_data_out = '0;
        dcache_response = '0;
        dcache_hit = 1'b0;
        dcache_tag = '0;
        // five rising edges under reset, then release on a falling edge
        repeat (5) @(posedge clk);
        next_cycle();
        reset = 1'b0;
        test_reset_state();
        test_load_hits();
        test_blocking_miss();
        test_store();
        test_full_order();
        $display("Test passed");
        $finish;
    end

endmodule

//--- flist.f
src/lsq_pkg.sv
src/lsq_entry.sv
src/lsq_alloc.sv
src/load_extend.sv
src/lsq_issue.sv
src/lsq.sv
verif/lsq_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module lsq_tb -f flist.f -o lsq_sim || exit 1
out=$(./obj_dir/lsq_sim)
echo "$out"
echo "$out" | grep -qx "Test passed" && exit 0 || exit 1
